/* source/board_display_pkg.sv */
`default_nettype none

package board_display_pkg;

    localparam int COLOR_W    = 2;
    localparam int SCORE_W    = 3;
    localparam int SEG_W      = 7;
    localparam int NUM_DIGITS = 8;
    localparam int SCAN_W     = $clog2(NUM_DIGITS);
    localparam int LCD_COLS   = 16;
    localparam int COL_W      = $clog2(LCD_COLS);
    localparam int TICK_W     = 9;

    // Step lengths in clock cycles
    localparam int LEN_POWER_UP = 71;
    localparam int LEN_CMD      = 31;
    localparam int LEN_LINE     = 21;
    localparam int LEN_HOME     = 401;
    localparam int LEN_CLEAR    = 201;

    localparam logic [7:0] CMD_FUNCTION_SET = 8'h3C;  // 8-bit bus, 2 lines
    localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06;  // Increment, no shift
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h0C;  // Cursor off
    localparam logic [7:0] CMD_HOME         = 8'h02;
    localparam logic [7:0] CMD_CLEAR        = 8'h01;
    localparam logic [7:0] CMD_ROW0_ADDR    = 8'h80;
    localparam logic [7:0] CMD_ROW1_ADDR    = 8'hC0;

    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_HEART = 8'h9D;  // Controller ROM glyph

    typedef enum logic [2:0] {
        POWER_UP,
        FUNCTION_SET,
        ENTRY_MODE,
        DISPLAY_ON,
        ROW0,
        ROW1,
        HOME,
        CLEAR
    } lcd_step_t;

    typedef enum logic [1:0] {
        MSG_BLANK,
        MSG_P1_WIN,
        MSG_P2_WIN
    } lcd_msg_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef struct packed {
        logic       e;
        logic       rs;
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    // Segment order a..g, MSB first
    function automatic logic [SEG_W-1:0] seg_pattern(input logic [SCORE_W-1:0] score);
        logic [SEG_W-1:0] pat;
        case (score)
            3'd1:    pat = 7'b0110000;
            3'd2:    pat = 7'b1101101;
            3'd3:    pat = 7'b1111001;
            3'd4:    pat = 7'b0110011;
            3'd5:    pat = 7'b1011011;
            default: pat = '0;  // Blank
        endcase
        return pat;
    endfunction

endpackage

`default_nettype wire

/* source/lcd_timer.sv */
`default_nettype none

module lcd_timer import board_display_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  lcd_step_t         step,
    output logic [TICK_W-1:0] tick,
    output logic              step_end
);

    logic [TICK_W-1:0] last_tick;

    always_comb begin
        case (step)
            POWER_UP:   last_tick = TICK_W'(LEN_POWER_UP - 1);
            ROW0, ROW1: last_tick = TICK_W'(LEN_LINE - 1);
            HOME:       last_tick = TICK_W'(LEN_HOME - 1);
            CLEAR:      last_tick = TICK_W'(LEN_CLEAR - 1);
            default:    last_tick = TICK_W'(LEN_CMD - 1);  // Setup commands
        endcase
    end

    assign step_end = (tick == last_tick);

    always_ff @(posedge clk) begin
        if (!rst) begin
            tick <= '0;
        end else if (step_end) begin
            tick <= '0;  // Restart with next step
        end else begin
            tick <= tick + TICK_W'(1);
        end
    end

endmodule

`default_nettype wire

/* source/lcd_text_rom.sv */
`default_nettype none

module lcd_text_rom import board_display_pkg::*; (
    input  lcd_msg_t         msg,
    input  logic             row,
    input  logic [COL_W-1:0] col,
    output logic [7:0]       char_code
);

    logic [7:0] player_char;

    assign player_char = (msg == MSG_P2_WIN) ? "2" : "1";

    always_comb begin
        char_code = CHAR_SPACE;
        if (msg != MSG_BLANK) begin
            if (!row) begin
                case (col)
                    4'd1:    char_code = "P";
                    4'd2:    char_code = player_char;
                    4'd4:    char_code = "W";  // 0x57
                    4'd5:    char_code = "i";
                    4'd6:    char_code = "n";
                    default: char_code = CHAR_SPACE;
                endcase
            end else begin
                // Two groups of three hearts
                case (col)
                    4'd1, 4'd2, 4'd3: char_code = CHAR_HEART;
                    4'd5, 4'd6, 4'd7: char_code = CHAR_HEART;
                    default:          char_code = CHAR_SPACE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/lcd_sequencer.sv */
`default_nettype none

module lcd_sequencer import board_display_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] lcd_sel,
    output lcd_bus_t   lcd
);

    lcd_step_t         step;
    lcd_step_t         step_next;
    lcd_msg_t          msg;
    lcd_msg_t          sel_msg;
    logic [TICK_W-1:0] tick;
    logic [TICK_W-1:0] tick_m1;
    logic              step_end;
    logic              row;
    logic [COL_W-1:0]  col;
    logic [7:0]        char_code;
    logic              wr;
    logic              wr_rs;
    logic [7:0]        wr_data;

    lcd_timer u_lcd_timer (
        .clk      (clk),
        .rst      (rst),
        .step     (step),
        .tick     (tick),
        .step_end (step_end)
    );

    lcd_text_rom u_lcd_text_rom (
        .msg       (msg),
        .row       (row),
        .col       (col),
        .char_code (char_code)
    );

    assign row     = (step == ROW1);
    assign tick_m1 = tick - TICK_W'(1);
    assign col     = tick_m1[COL_W-1:0];  // Tick 1 is column 0

    always_comb begin
        case (lcd_sel)
            2'b01:   sel_msg = MSG_P1_WIN;
            2'b10:   sel_msg = MSG_P2_WIN;
            default: sel_msg = MSG_BLANK;
        endcase
    end

    always_comb begin
        case (step)
            POWER_UP:     step_next = FUNCTION_SET;
            FUNCTION_SET: step_next = ENTRY_MODE;
            ENTRY_MODE:   step_next = DISPLAY_ON;
            DISPLAY_ON:   step_next = ROW0;
            ROW0:         step_next = ROW1;
            ROW1:         step_next = HOME;
            HOME:         step_next = CLEAR;
            default:      step_next = ROW0;  // Refresh loop
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            step <= POWER_UP;
            msg  <= MSG_BLANK;
        end else if (step_end) begin
            step <= step_next;
            if (step_next == ROW0) begin
                msg <= sel_msg;  // Held for the whole pass
            end
        end
    end

    always_comb begin
        wr      = 1'b0;
        wr_rs   = 1'b0;
        wr_data = CMD_CLEAR;
        case (step)
            FUNCTION_SET: begin
                wr      = (tick == '0);
                wr_data = CMD_FUNCTION_SET;
            end
            ENTRY_MODE: begin
                wr      = (tick == '0);
                wr_data = CMD_ENTRY_MODE;
            end
            DISPLAY_ON: begin
                wr      = (tick == '0);
                wr_data = CMD_DISPLAY_ON;
            end
            HOME: begin
                wr      = (tick == '0);
                wr_data = CMD_HOME;
            end
            CLEAR: begin
                wr      = (tick == '0);
                wr_data = CMD_CLEAR;
            end
            ROW0, ROW1: begin
                if (tick == '0) begin
                    wr      = 1'b1;
                    wr_data = row ? CMD_ROW1_ADDR : CMD_ROW0_ADDR;
                end else if (tick <= TICK_W'(LCD_COLS)) begin
                    wr      = 1'b1;
                    wr_rs   = 1'b1;  // Character data
                    wr_data = char_code;
                end
            end
            default: wr = 1'b0;  // Power-up wait
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd <= '0;
        end else begin
            lcd.e <= wr;  // One-cycle strobe
            if (wr) begin
                lcd.rs   <= wr_rs;
                lcd.rw   <= 1'b0;
                lcd.data <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/panel_scanner.sv */
`default_nettype none

module panel_scanner import board_display_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [COLOR_W-1:0]    color1,
    input  logic [COLOR_W-1:0]    color2,
    input  logic [SCORE_W-1:0]    score1,
    input  logic [SCORE_W-1:0]    score2,
    output rgb_t                  led1,
    output rgb_t                  led2,
    output logic [SEG_W-1:0]      seg,
    output logic [NUM_DIGITS-1:0] digit_sel
);

    logic [SEG_W-1:0]  seg1_q;
    logic [SEG_W-1:0]  seg2_q;
    logic [SCAN_W-1:0] scan_cnt;

    function automatic rgb_t color_decode(input logic [COLOR_W-1:0] color);
        rgb_t led;
        led = '0;
        case (color)
            2'b01:   led.r = 1'b1;
            2'b10:   led.g = 1'b1;
            2'b11:   led.b = 1'b1;
            default: led = '0;  // Off
        endcase
        return led;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            led1 <= '0;
            led2 <= '0;
        end else begin
            led1 <= color_decode(color1);
            led2 <= color_decode(color2);
        end
    end

    // First stage of the score path
    always_ff @(posedge clk) begin
        seg1_q <= seg_pattern(score1);
        seg2_q <= seg_pattern(score2);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            scan_cnt  <= '0;
            seg       <= '0;
            digit_sel <= '0;
        end else begin
            scan_cnt  <= scan_cnt + SCAN_W'(1);  // Free running
            digit_sel <= NUM_DIGITS'(1) << scan_cnt;
            if (scan_cnt == '0) begin
                seg <= seg1_q;  // Leftmost digit
            end else if (scan_cnt == SCAN_W'(NUM_DIGITS - 1)) begin
                seg <= seg2_q;  // Rightmost digit
            end else begin
                seg <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/board_display_top.sv */
`default_nettype none

module board_display_top import board_display_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [COLOR_W-1:0]    color1,
    input  logic [COLOR_W-1:0]    color2,
    input  logic [SCORE_W-1:0]    score1,
    input  logic [SCORE_W-1:0]    score2,
    input  logic [1:0]            lcd_sel,
    output rgb_t                  led1,
    output rgb_t                  led2,
    output logic [SEG_W-1:0]      seg,
    output logic [NUM_DIGITS-1:0] digit_sel,
    output lcd_bus_t              lcd
);

    panel_scanner u_panel_scanner (
        .clk       (clk),
        .rst       (rst),
        .color1    (color1),
        .color2    (color2),
        .score1    (score1),
        .score2    (score2),
        .led1      (led1),
        .led2      (led2),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

    lcd_sequencer u_lcd_sequencer (
        .clk     (clk),
        .rst     (rst),
        .lcd_sel (lcd_sel),
        .lcd     (lcd)
    );

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/board_display_tb.sv */
`default_nettype none

module board_display_tb import board_display_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst;
    logic [COLOR_W-1:0]    color1;
    logic [COLOR_W-1:0]    color2;
    logic [SCORE_W-1:0]    score1;
    logic [SCORE_W-1:0]    score2;
    logic [1:0]            lcd_sel;
    rgb_t                  led1;
    rgb_t                  led2;
    logic [SEG_W-1:0]      seg;
    logic [NUM_DIGITS-1:0] digit_sel;
    lcd_bus_t              lcd;

    logic [15:0] lfsr;
    lcd_msg_t    exp_msg;   // Message for the next pass
    lcd_msg_t    pass_msg;
    logic [8:0]  first_writes [$];
    int          wr_count;
    int          passes_done;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    board_display_top u_board_display_top (
        .clk       (clk),
        .rst       (rst),
        .color1    (color1),
        .color2    (color2),
        .score1    (score1),
        .score2    (score2),
        .lcd_sel   (lcd_sel),
        .led1      (led1),
        .led2      (led2),
        .seg       (seg),
        .digit_sel (digit_sel),
        .lcd       (lcd)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);  // One step per bit
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic rgb_t expected_led(input logic [COLOR_W-1:0] c);
        rgb_t l;
        l.r = (c == 2'b01);
        l.g = (c == 2'b10);
        l.b = (c == 2'b11);
        return l;
    endfunction

    function automatic logic [7:0] expected_char(input lcd_msg_t m, input int row, input int col);
        string      txt;
        logic [7:0] c;
        txt = (m == MSG_P2_WIN) ? " P2 Win" : " P1 Win";
        c   = CHAR_SPACE;
        if (m != MSG_BLANK && row == 0 && col < txt.len()) begin
            c = txt[col];
        end else if (m != MSG_BLANK && row == 1 && col != 0 && col != 4 && col < 8) begin
            c = CHAR_HEART;  // Two groups of three
        end
        return c;
    endfunction

    // Returns {rs, data} of the k-th write after reset
    function automatic logic [8:0] expected_write(input int k, input lcd_msg_t m);
        int         p;
        logic [8:0] w;
        p = (k - 3) % 36;  // Position within a refresh pass
        if (k == 0) w = {1'b0, CMD_FUNCTION_SET};
        else if (k == 1) w = {1'b0, CMD_ENTRY_MODE};
        else if (k == 2) w = {1'b0, CMD_DISPLAY_ON};
        else if (p == 0) w = {1'b0, CMD_ROW0_ADDR};
        else if (p <= 16) w = {1'b1, expected_char(m, 0, p - 1)};
        else if (p == 17) w = {1'b0, CMD_ROW1_ADDR};
        else if (p <= 33) w = {1'b1, expected_char(m, 1, p - 18)};
        else if (p == 34) w = {1'b0, CMD_HOME};
        else w = {1'b0, CMD_CLEAR};
        return w;
    endfunction

    task automatic wait_writes(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (!timed_out && wr_count < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!timed_out && wr_count < target) begin
            $display("Timed out after %0d cycles waiting for LCD write %0d", limit, target);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_passes(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (!timed_out && passes_done < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!timed_out && passes_done < target) begin
            $display("Timed out after %0d cycles waiting for LCD pass %0d", limit, target);
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before || timed_out) begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
    endtask

    // LCD write monitor, counts strobes
    initial begin
        logic [8:0] got;
        logic [8:0] exp;
        int         pos;
        forever begin
            @(negedge clk);
            if (rst && lcd.e) begin
                pos = (wr_count - 3) % 36;
                if (wr_count >= 3 && pos == 0) begin
                    pass_msg = exp_msg;  // Taken at pass start
                end
                got = {lcd.rs, lcd.data};
                exp = expected_write(wr_count, pass_msg);
                if (first_writes.size() < 4) begin
                    first_writes.push_back(got);
                end
                assert (got == exp && lcd.rw == 1'b0) else begin
                    $display("Fail at %0t ns: LCD write %0d expected %h, got %h, rw %b",
                             $time, wr_count, exp, got, lcd.rw);
                    errors++;
                end
                if (wr_count >= 3 && pos == 35) begin
                    passes_done++;
                end
                wr_count++;
            end
        end
    end

    initial begin
        logic [7:0]            v;
        logic [7:0]            w;
        logic [SEG_W-1:0]      exp_seg;
        logic [NUM_DIGITS-1:0] visited;
        logic [7:0]            init_cmds [$];
        logic [1:0]            sels [$];
        lcd_msg_t              msgs [$];
        int                    e0;
        int                    cycles;
        color1      = '0;
        color2      = '0;
        score1      = '0;
        score2      = '0;
        lcd_sel     = '0;
        lfsr        = 16'd8;
        exp_msg     = MSG_BLANK;
        pass_msg    = MSG_BLANK;
        wr_count    = 0;
        passes_done = 0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        timed_out   = 1'b0;

        e0     = errors;
        cycles = 0;
        while (rst !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b1) begin
            $display("Timed out waiting for reset release");
            timed_out = 1'b1;
        end
        assert (lcd.e === 1'b0 && seg === '0 && digit_sel === '0 && led1 === '0
                && led2 === '0) else begin
            $display("Fail at %0t ns: outputs not cleared by reset", $time);
            errors++;
        end
        end_test("reset values", e0);

        if (!timed_out) begin
            e0 = errors;
            for (int i = 0; i < 12; i++) begin
                @(posedge clk);
                if (i < 4) begin
                    v = 8'(i);  // Every code on both LEDs
                    w = 8'(3 - i);
                end else begin
                    take_bits(COLOR_W, v);
                    take_bits(COLOR_W, w);
                end
                color1 <= v[COLOR_W-1:0];
                color2 <= w[COLOR_W-1:0];
                repeat (3) @(negedge clk);
                assert (led1 == expected_led(v[COLOR_W-1:0])
                        && led2 == expected_led(w[COLOR_W-1:0])) else begin
                    $display("Fail at %0t ns: colours %b %b gave leds %b %b",
                             $time, v[1:0], w[1:0], led1, led2);
                    errors++;
                end
            end
            end_test("LED colours", e0);
        end

        if (!timed_out) begin
            e0 = errors;
            repeat (6) begin
                @(posedge clk);
                take_bits(SCORE_W, v);
                take_bits(SCORE_W, w);
                score1 <= v[SCORE_W-1:0];
                score2 <= w[SCORE_W-1:0];
                visited = '0;
                for (int i = 0; i < 20; i++) begin
                    @(negedge clk);
                    if (i >= 3) begin  // Past the score latency
                        visited |= digit_sel;
                        if (digit_sel == NUM_DIGITS'(1)) begin
                            exp_seg = seg_pattern(v[SCORE_W-1:0]);
                        end else if (digit_sel[NUM_DIGITS-1]) begin
                            exp_seg = seg_pattern(w[SCORE_W-1:0]);
                        end else begin
                            exp_seg = '0;
                        end
                        assert ($onehot(digit_sel) && seg == exp_seg) else begin
                            $display("Fail at %0t ns: digit_sel %b seg %b, expected seg %b",
                                     $time, digit_sel, seg, exp_seg);
                            errors++;
                        end
                    end
                end
                assert (&visited) else begin
                    $display("Fail at %0t ns: scan visited only %b", $time, visited);
                    errors++;
                end
            end
            end_test("score scan", e0);
        end

        if (!timed_out) begin
            e0 = errors;
            init_cmds = {CMD_FUNCTION_SET, CMD_ENTRY_MODE, CMD_DISPLAY_ON, CMD_ROW0_ADDR};
            wait_writes(4, 2000);
            for (int i = 0; i < 4 && !timed_out; i++) begin
                assert (first_writes[i] == {1'b0, init_cmds[i]}) else begin
                    $display("Fail at %0t ns: init write %0d is %h, expected %h",
                             $time, i, first_writes[i], {1'b0, init_cmds[i]});
                    errors++;
                end
            end
            end_test("LCD init order", e0);
        end

        sels = {2'b01, 2'b10, 2'b00};
        msgs = {MSG_P1_WIN, MSG_P2_WIN, MSG_BLANK};
        for (int m = 0; m < 3 && !timed_out; m++) begin
            e0 = errors;
            wait_passes(passes_done + 1, 1500);
            @(posedge clk);
            lcd_sel <= sels[m];  // During the clear step
            exp_msg  = msgs[m];
            wait_passes(passes_done + 2, 3000);
            end_test($sformatf("LCD passes with lcd_sel %b", sels[m]), e0);
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/board_display_pkg.sv
source/lcd_timer.sv
source/lcd_text_rom.sv
source/lcd_sequencer.sv
source/panel_scanner.sv
source/board_display_top.sv
verification/clock_gen.sv
verification/board_display_tb.sv

/* Makefile */
TOP := board_display_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module board_display_top
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
